/* logic/mbox_pkg.sv */
// Shared widths, register offsets, AXI response codes and FIFO depths
// for the AXI4-Lite mailbox
`default_nettype none

package mbox_pkg;

        // ------------------------------------------------------------------
        // Bus widths
        // ------------------------------------------------------------------
        // Word carried by AXI data and both streams
        typedef logic [31:0] data_t;
        // Register offset, 0x0 to 0xC
        typedef logic [3:0]  addr_t;
        typedef logic [1:0]  resp_t;

        // AXI response codes
        localparam resp_t RESP_OKAY   = 2'b00;
        localparam resp_t RESP_SLVERR = 2'b10;
        localparam resp_t RESP_DECERR = 2'b11;

        // ------------------------------------------------------------------
        // Register map
        // ------------------------------------------------------------------
        localparam addr_t REG_TXDATA = 4'h0;
        localparam addr_t REG_RXDATA = 4'h4;
        localparam addr_t REG_STATUS = 4'h8;

        // FIFO sizing
        localparam int TX_DEPTH      = 8;
        localparam int RX_DEPTH      = 4;
        // Shared by almost-full and almost-empty thresholds
        localparam int ALMOST_MARGIN = 1;

        // Per-channel state of the register block
        typedef enum logic {
                ST_IDLE,
                ST_RESP
        } axil_state_t;

endpackage : mbox_pkg

`default_nettype wire

/* logic/fifo_flags.sv */
// FIFO status flags: full, empty, almost flags and fill count
`timescale 1ns/100ps
`default_nettype none

module fifo_flags #(
        parameter int DEPTH = 4
) (
        input  wire logic                     axi_aclk,
        input  wire logic                     axi_aresetn,
        input  wire logic [$clog2(DEPTH):0]   i_wr_ptr_next,
        input  wire logic [$clog2(DEPTH):0]   i_rd_ptr_next,
        output logic      [$clog2(DEPTH):0]   o_count,
        output logic                          o_full,
        output logic                          o_empty,
        output logic                          o_almost_full,
        output logic                          o_almost_empty
);

        import mbox_pkg::*;

        // Fill level seen after this edge
        logic [$clog2(DEPTH):0] w_count_next;

        // Extra pointer bit makes the plain difference wrap correctly
        assign w_count_next = i_wr_ptr_next - i_rd_ptr_next;

        // ------------------------------------------------------------------
        // Registered flags
        // ------------------------------------------------------------------
        always_ff @(posedge axi_aclk) begin
                if (!axi_aresetn) begin
                        o_count        <= '0;
                        o_full         <= 1'b0;
                        o_empty        <= 1'b1;
                        o_almost_full  <= 1'b0;
                        o_almost_empty <= 1'b1;
                end else begin
                        o_count        <= w_count_next;
                        o_full         <= (w_count_next == DEPTH);
                        o_empty        <= (w_count_next == 0);
                        // Within margin of the top
                        o_almost_full  <= (w_count_next >= DEPTH - ALMOST_MARGIN);
                        // Within margin of the bottom
                        o_almost_empty <= (w_count_next <= ALMOST_MARGIN);
                end
        end

        // Each pointer moves by one word at most, so the count does too
        a_count_step : assert property (
                @(posedge axi_aclk) disable iff (!axi_aresetn)
                (o_count == $past(o_count)) ||
                (o_count == $past(o_count) + 1'b1) ||
                (o_count == $past(o_count) - 1'b1)
        );

endmodule : fifo_flags

`default_nettype wire

/* logic/gaxi_fifo_sync.sv */
// Single-clock valid/ready FIFO with binary pointers and a
// combinational-read storage array
`timescale 1ns/100ps
`default_nettype none

module gaxi_fifo_sync #(
        parameter int DEPTH = 4
) (
        input  wire logic                     axi_aclk,
        input  wire logic                     axi_aresetn,
        // Write side
        input  wire logic                     i_wr_valid,
        output logic                          o_wr_ready,
        input  wire mbox_pkg::data_t          i_wr_data,
        // Read side
        input  wire logic                     i_rd_ready,
        output logic                          o_rd_valid,
        output mbox_pkg::data_t               o_rd_data,
        // Status
        output logic      [$clog2(DEPTH):0]   o_count,
        output logic                          o_almost_full,
        output logic                          o_almost_empty
);

        import mbox_pkg::*;

        localparam int AW = $clog2(DEPTH);

        logic [AW:0] r_wr_ptr;
        logic [AW:0] r_rd_ptr;
        logic [AW:0] w_wr_ptr_next;
        logic [AW:0] w_rd_ptr_next;
        logic        w_full;
        logic        w_empty;
        logic        w_write;
        logic        w_read;
        data_t       mem [DEPTH];

        // Handshakes
        assign w_write = i_wr_valid && o_wr_ready;
        assign w_read  = i_rd_ready && o_rd_valid;

        // ------------------------------------------------------------------
        // Pointers, one bit wider than the address
        // ------------------------------------------------------------------
        assign w_wr_ptr_next = r_wr_ptr + {{AW{1'b0}}, w_write};
        assign w_rd_ptr_next = r_rd_ptr + {{AW{1'b0}}, w_read};

        always_ff @(posedge axi_aclk) begin
                if (!axi_aresetn) begin
                        r_wr_ptr <= '0;
                        r_rd_ptr <= '0;
                end else begin
                        r_wr_ptr <= w_wr_ptr_next;
                        r_rd_ptr <= w_rd_ptr_next;
                end
        end

        // Flags registered from the next pointers
        fifo_flags #(
                .DEPTH          (DEPTH)
        ) u_flags (
                .axi_aclk       (axi_aclk),
                .axi_aresetn    (axi_aresetn),
                .i_wr_ptr_next  (w_wr_ptr_next),
                .i_rd_ptr_next  (w_rd_ptr_next),
                .o_count        (o_count),
                .o_full         (w_full),
                .o_empty        (w_empty),
                .o_almost_full  (o_almost_full),
                .o_almost_empty (o_almost_empty)
        );

        assign o_wr_ready = !w_full;
        assign o_rd_valid = !w_empty;

        // Storage, indexed by low pointer bits
        always_ff @(posedge axi_aclk) begin
                if (w_write) begin
                        mem[r_wr_ptr[AW-1:0]] <= i_wr_data;
                end
        end

        // Head entry, no read latency
        assign o_rd_data = mem[r_rd_ptr[AW-1:0]];

        a_count_bound : assert property (
                @(posedge axi_aclk) disable iff (!axi_aresetn)
                o_count <= DEPTH
        );

        // When full the write slot is the head, which must not be overwritten
        a_no_write_full : assert property (
                @(posedge axi_aclk) disable iff (!axi_aresetn)
                (w_full && !w_read) |=> $stable(o_rd_data)
        );

endmodule : gaxi_fifo_sync

`default_nettype wire

/* logic/axil_mbox_regs.sv */
// AXI4-Lite register slave for the mailbox: TXDATA push, RXDATA pop,
// STATUS readback and response generation
`timescale 1ns/100ps
`default_nettype none

module axil_mbox_regs (
        input  wire logic                                axi_aclk,
        input  wire logic                                axi_aresetn,
        // AXI4-Lite write channels
        input  wire mbox_pkg::addr_t                     i_awaddr,
        input  wire logic                                i_awvalid,
        output logic                                     o_awready,
        input  wire mbox_pkg::data_t                     i_wdata,
        input  wire logic                                i_wvalid,
        output logic                                     o_wready,
        output mbox_pkg::resp_t                          o_bresp,
        output logic                                     o_bvalid,
        input  wire logic                                i_bready,
        // AXI4-Lite read channels
        input  wire mbox_pkg::addr_t                     i_araddr,
        input  wire logic                                i_arvalid,
        output logic                                     o_arready,
        output mbox_pkg::data_t                          o_rdata,
        output mbox_pkg::resp_t                          o_rresp,
        output logic                                     o_rvalid,
        input  wire logic                                i_rready,
        // Transmit FIFO
        output logic                                     o_tx_push,
        output mbox_pkg::data_t                          o_tx_push_data,
        input  wire logic                                i_tx_ready,
        input  wire logic [$clog2(mbox_pkg::TX_DEPTH):0] i_tx_count,
        input  wire logic                                i_tx_almost_full,
        // Receive FIFO
        output logic                                     o_rx_pop,
        input  wire logic                                i_rx_valid,
        input  wire mbox_pkg::data_t                     i_rx_data,
        input  wire logic [$clog2(mbox_pkg::RX_DEPTH):0] i_rx_count,
        input  wire logic                                i_rx_almost_empty
);

        import mbox_pkg::*;

        axil_state_t r_wr_state;
        axil_state_t r_rd_state;
        logic        w_wr_accept;
        logic        w_rd_accept;
        resp_t       w_wr_resp;
        resp_t       w_rd_resp;
        data_t       w_rd_word;
        data_t       w_status;
        resp_t       r_bresp;
        resp_t       r_rresp;
        data_t       r_rdata;

        // ------------------------------------------------------------------
        // Write channel
        // ------------------------------------------------------------------
        // Needs address and data together, and no pending response
        assign w_wr_accept = (r_wr_state == ST_IDLE) && i_awvalid && i_wvalid;
        assign o_awready   = w_wr_accept;
        assign o_wready    = w_wr_accept;

        // Push only when the FIFO has room
        assign o_tx_push      = w_wr_accept && (i_awaddr == REG_TXDATA) && i_tx_ready;
        assign o_tx_push_data = i_wdata;

        always_comb begin
                case (i_awaddr)
                        REG_TXDATA: w_wr_resp = i_tx_ready ? RESP_OKAY : RESP_SLVERR;
                        // Read-only registers
                        REG_RXDATA,
                        REG_STATUS: w_wr_resp = RESP_SLVERR;
                        default:    w_wr_resp = RESP_DECERR;
                endcase
        end

        always_ff @(posedge axi_aclk) begin
                if (!axi_aresetn) begin
                        r_wr_state <= ST_IDLE;
                end else if (w_wr_accept) begin
                        r_wr_state <= ST_RESP;
                end else if (r_wr_state == ST_RESP && i_bready) begin
                        r_wr_state <= ST_IDLE;
                end
        end

        // Response code latched at acceptance
        always_ff @(posedge axi_aclk) begin
                if (w_wr_accept) begin
                        r_bresp <= w_wr_resp;
                end
        end

        assign o_bvalid = (r_wr_state == ST_RESP);
        assign o_bresp  = r_bresp;

        // ------------------------------------------------------------------
        // Read channel
        // ------------------------------------------------------------------
        assign w_rd_accept = (r_rd_state == ST_IDLE) && i_arvalid;
        assign o_arready   = w_rd_accept;

        // Pop in the acceptance cycle, head word captured below
        assign o_rx_pop = w_rd_accept && (i_araddr == REG_RXDATA) && i_rx_valid;

        // Status word
        always_comb begin
                w_status        = '0;
                w_status[7:0]   = 8'(i_tx_count);
                w_status[15:8]  = 8'(i_rx_count);
                w_status[16]    = i_tx_almost_full;
                w_status[17]    = i_rx_almost_empty;
        end

        always_comb begin
                w_rd_word = '0;
                case (i_araddr)
                        REG_RXDATA: begin
                                // Empty FIFO returns zero
                                w_rd_word = i_rx_valid ? i_rx_data : '0;
                                w_rd_resp = i_rx_valid ? RESP_OKAY : RESP_SLVERR;
                        end
                        REG_STATUS: begin
                                w_rd_word = w_status;
                                w_rd_resp = RESP_OKAY;
                        end
                        // Write-only
                        REG_TXDATA: w_rd_resp = RESP_SLVERR;
                        default:    w_rd_resp = RESP_DECERR;
                endcase
        end

        always_ff @(posedge axi_aclk) begin
                if (!axi_aresetn) begin
                        r_rd_state <= ST_IDLE;
                end else if (w_rd_accept) begin
                        r_rd_state <= ST_RESP;
                end else if (r_rd_state == ST_RESP && i_rready) begin
                        r_rd_state <= ST_IDLE;
                end
        end

        always_ff @(posedge axi_aclk) begin
                if (w_rd_accept) begin
                        r_rdata <= w_rd_word;
                        r_rresp <= w_rd_resp;
                end
        end

        assign o_rvalid = (r_rd_state == ST_RESP);
        assign o_rdata  = r_rdata;
        assign o_rresp  = r_rresp;

        // Pending responses hold, unchanged, until taken
        a_bresp_hold : assert property (
                @(posedge axi_aclk) disable iff (!axi_aresetn)
                (o_bvalid && !i_bready) |=> (o_bvalid && $stable(o_bresp))
        );

        a_rresp_hold : assert property (
                @(posedge axi_aclk) disable iff (!axi_aresetn)
                (o_rvalid && !i_rready) |=>
                        (o_rvalid && $stable(o_rdata) && $stable(o_rresp))
        );

endmodule : axil_mbox_regs

`default_nettype wire

/* logic/mbox_top.sv */
// Mailbox top level: AXI4-Lite register block with transmit and
// receive FIFOs
`timescale 1ns/100ps
`default_nettype none

module mbox_top (
        input  wire logic              axi_aclk,
        input  wire logic              axi_aresetn,
        // AXI4-Lite
        input  wire mbox_pkg::addr_t   i_awaddr,
        input  wire logic              i_awvalid,
        output logic                   o_awready,
        input  wire mbox_pkg::data_t   i_wdata,
        input  wire logic              i_wvalid,
        output logic                   o_wready,
        output mbox_pkg::resp_t        o_bresp,
        output logic                   o_bvalid,
        input  wire logic              i_bready,
        input  wire mbox_pkg::addr_t   i_araddr,
        input  wire logic              i_arvalid,
        output logic                   o_arready,
        output mbox_pkg::data_t        o_rdata,
        output mbox_pkg::resp_t        o_rresp,
        output logic                   o_rvalid,
        input  wire logic              i_rready,
        // Transmit stream
        output logic                   o_tx_valid,
        output mbox_pkg::data_t        o_tx_data,
        input  wire logic              i_tx_ready,
        // Receive stream
        input  wire logic              i_rx_valid,
        input  wire mbox_pkg::data_t   i_rx_data,
        output logic                   o_rx_ready
);

        import mbox_pkg::*;

        // Transmit FIFO write side and status
        logic                        tx_push;
        data_t                       tx_push_data;
        logic                        tx_fifo_ready;
        logic [$clog2(TX_DEPTH):0]   tx_count;
        logic                        tx_almost_full;
        // Receive FIFO read side and status
        logic                        rx_pop;
        logic                        rx_fifo_valid;
        data_t                       rx_fifo_data;
        logic [$clog2(RX_DEPTH):0]   rx_count;
        logic                        rx_almost_empty;

        axil_mbox_regs u_regs (
                .axi_aclk (axi_aclk), .axi_aresetn (axi_aresetn),
                .i_awaddr (i_awaddr), .i_awvalid (i_awvalid), .o_awready (o_awready),
                .i_wdata (i_wdata), .i_wvalid (i_wvalid), .o_wready (o_wready),
                .o_bresp (o_bresp), .o_bvalid (o_bvalid), .i_bready (i_bready),
                .i_araddr (i_araddr), .i_arvalid (i_arvalid), .o_arready (o_arready),
                .o_rdata (o_rdata), .o_rresp (o_rresp), .o_rvalid (o_rvalid),
                .i_rready (i_rready),
                .o_tx_push (tx_push), .o_tx_push_data (tx_push_data),
                .i_tx_ready (tx_fifo_ready), .i_tx_count (tx_count),
                .i_tx_almost_full (tx_almost_full),
                .o_rx_pop (rx_pop), .i_rx_valid (rx_fifo_valid),
                .i_rx_data (rx_fifo_data), .i_rx_count (rx_count),
                .i_rx_almost_empty (rx_almost_empty)
        );

        // Drains onto the transmit stream
        gaxi_fifo_sync #(.DEPTH(TX_DEPTH)) u_tx_fifo (
                .axi_aclk (axi_aclk), .axi_aresetn (axi_aresetn),
                .i_wr_valid (tx_push), .o_wr_ready (tx_fifo_ready),
                .i_wr_data (tx_push_data),
                .i_rd_ready (i_tx_ready), .o_rd_valid (o_tx_valid), .o_rd_data (o_tx_data),
                .o_count (tx_count), .o_almost_full (tx_almost_full), .o_almost_empty ()
        );

        // Fills from the receive stream, ready is not-full
        gaxi_fifo_sync #(.DEPTH(RX_DEPTH)) u_rx_fifo (
                .axi_aclk (axi_aclk), .axi_aresetn (axi_aresetn),
                .i_wr_valid (i_rx_valid), .o_wr_ready (o_rx_ready), .i_wr_data (i_rx_data),
                .i_rd_ready (rx_pop), .o_rd_valid (rx_fifo_valid), .o_rd_data (rx_fifo_data),
                .o_count (rx_count), .o_almost_full (), .o_almost_empty (rx_almost_empty)
        );

endmodule : mbox_top

`default_nettype wire

/* tb/tb_mbox_top.sv */
// Testbench for the AXI4-Lite mailbox: register accesses, stream traffic,
// protocol assertions and a watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_mbox_top;

        import mbox_pkg::*;

        localparam int CLK_PERIOD  = 100;
        // Rough cycle budget of all tests
        localparam int TEST_CYCLES = 200;
        // Transmit ready modes
        localparam int TX_HOLD     = 0;
        localparam int TX_RANDOM   = 1;
        localparam int TX_OPEN     = 2;

        logic    axi_aclk = 1'b0;
        logic    axi_aresetn;
        addr_t   i_awaddr;
        logic    i_awvalid;
        logic    o_awready;
        data_t   i_wdata;
        logic    i_wvalid;
        logic    o_wready;
        resp_t   o_bresp;
        logic    o_bvalid;
        logic    i_bready;
        addr_t   i_araddr;
        logic    i_arvalid;
        logic    o_arready;
        data_t   o_rdata;
        resp_t   o_rresp;
        logic    o_rvalid;
        logic    i_rready;
        logic    o_tx_valid;
        data_t   o_tx_data;
        logic    i_tx_ready = 1'b0;
        logic    i_rx_valid;
        data_t   i_rx_data;
        logic    o_rx_ready;

        int      tx_mode = TX_HOLD;
        bit      rx_done;
        // Words expected on the transmit stream and from RXDATA, in order
        data_t   tx_model[$];
        data_t   rx_model[$];

        mbox_top uut (.*);

        initial begin
                forever begin
                        #(CLK_PERIOD / 2) axi_aclk = ~axi_aclk;
                end
        end

        // ------------------------------------------------------------------
        // Reporting
        // ------------------------------------------------------------------
        task automatic fail_run();
                $display("Test failed");
                $fatal(1, "Simulation stopped at the first error");
        endtask

        task automatic report_problem(input string msg);
                $display("Error at time %0t: %s", $time, msg);
                fail_run();
        endtask

        task automatic check_value(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
                if (act !== exp) begin
                        $display("Error at time %0t: %s expected %h, actual %h",
                                 $time, name, exp, act);
                        fail_run();
                end
        endtask

        // STATUS layout: counts in bytes 0 and 1, almost flags in bits 16 and 17
        function automatic data_t status_word(input int tx_cnt, input int rx_cnt);
                status_word = {14'd0, (rx_cnt <= ALMOST_MARGIN),
                               (tx_cnt >= TX_DEPTH - ALMOST_MARGIN), 8'(rx_cnt), 8'(tx_cnt)};
        endfunction

        // ------------------------------------------------------------------
        // Bus and stream drivers
        // ------------------------------------------------------------------
        task automatic step_to_drive();
                @(posedge axi_aclk);
                #10;
        endtask

        task automatic write_reg(input addr_t addr, input data_t data, input resp_t exp_resp);
                step_to_drive();
                i_awaddr  = addr;
                i_wdata   = data;
                i_awvalid = 1'b1;
                i_wvalid  = 1'b1;
                i_bready  = 1'b1;
                @(negedge axi_aclk);
                while (!o_awready) @(negedge axi_aclk);
                step_to_drive();
                i_awvalid = 1'b0;
                i_wvalid  = 1'b0;
                @(negedge axi_aclk);
                while (!o_bvalid) @(negedge axi_aclk);
                check_value("o_bresp", exp_resp, o_bresp);
        endtask

        task automatic read_reg(input addr_t addr, input data_t exp_data, input resp_t exp_resp,
                                input bit check_data);
                step_to_drive();
                i_araddr  = addr;
                i_arvalid = 1'b1;
                i_rready  = 1'b1;
                @(negedge axi_aclk);
                while (!o_arready) @(negedge axi_aclk);
                step_to_drive();
                i_arvalid = 1'b0;
                @(negedge axi_aclk);
                while (!o_rvalid) @(negedge axi_aclk);
                check_value("o_rresp", exp_resp, o_rresp);
                if (check_data) begin
                        check_value("o_rdata", exp_data, o_rdata);
                end
        endtask

        // Random words onto the receive stream, each held until taken
        task automatic offer_rx_words(input int n);
                data_t word;
                for (int i = 0; i < n; i++) begin
                        word = $urandom;
                        step_to_drive();
                        i_rx_valid = 1'b1;
                        i_rx_data  = word;
                        @(negedge axi_aclk);
                        while (!o_rx_ready) @(negedge axi_aclk);
                        rx_model.push_back(word);
                end
                step_to_drive();
                i_rx_valid = 1'b0;
                rx_done    = 1'b1;
        endtask

        // Write and STATUS read together, both responses stalled for a while
        task automatic hold_responses(input int cycles);
                data_t word;
                word = $urandom;
                tx_model.push_back(word);
                step_to_drive();
                i_awaddr  = REG_TXDATA;
                i_wdata   = word;
                i_araddr  = REG_STATUS;
                i_awvalid = 1'b1;
                i_wvalid  = 1'b1;
                i_arvalid = 1'b1;
                i_bready  = 1'b0;
                i_rready  = 1'b0;
                @(negedge axi_aclk);
                while (!(o_awready && o_arready)) @(negedge axi_aclk);
                // Requests stay offered while responses are pending
                repeat (cycles) begin
                        @(negedge axi_aclk);
                        check_value("o_bvalid", 1'b1, o_bvalid);
                        check_value("o_rvalid", 1'b1, o_rvalid);
                end
                step_to_drive();
                i_awvalid = 1'b0;
                i_wvalid  = 1'b0;
                i_arvalid = 1'b0;
                i_bready  = 1'b1;
                i_rready  = 1'b1;
                @(negedge axi_aclk);
                check_value("o_bresp", RESP_OKAY, o_bresp);
                check_value("o_rresp", RESP_OKAY, o_rresp);
                check_value("o_rdata", status_word(0, 0), o_rdata);
        endtask

        task automatic wait_tx_drained();
                @(negedge axi_aclk);
                while (tx_model.size() != 0 || o_tx_valid) @(negedge axi_aclk);
        endtask

        // Transmit ready, per mode
        always @(posedge axi_aclk) begin
                #10;
                case (tx_mode)
                        TX_RANDOM: i_tx_ready = 1'($urandom % 2);
                        TX_OPEN:   i_tx_ready = 1'b1;
                        default:   i_tx_ready = 1'b0;
                endcase
        end

        // Transmit stream order against write order
        always @(negedge axi_aclk) begin
                if (axi_aresetn && o_tx_valid && i_tx_ready) begin
                        if (tx_model.size() == 0) begin
                                report_problem("Transmit stream word with no pending write");
                        end else begin
                                check_value("o_tx_data", tx_model.pop_front(), o_tx_data);
                        end
                end
        end

        // ------------------------------------------------------------------
        // Protocol assertions
        // ------------------------------------------------------------------
        a_bvalid_latency : assert property (
                @(posedge axi_aclk) disable iff (!axi_aresetn)
                (i_awvalid && o_awready) |=> o_bvalid
        ) else report_problem("BVALID did not follow write acceptance by one cycle");

        a_rvalid_latency : assert property (
                @(posedge axi_aclk) disable iff (!axi_aresetn)
                (i_arvalid && o_arready) |=> o_rvalid
        ) else report_problem("RVALID did not follow read acceptance by one cycle");

        // Address and data are taken in the same cycle
        a_aw_w_ready : assert property (
                @(posedge axi_aclk) disable iff (!axi_aresetn)
                o_awready == o_wready
        ) else report_problem("AWREADY and WREADY were not raised together");

        a_no_aw_pending : assert property (
                @(posedge axi_aclk) disable iff (!axi_aresetn)
                o_bvalid |-> !o_awready
        ) else report_problem("Write accepted while a write response was pending");

        a_no_ar_pending : assert property (
                @(posedge axi_aclk) disable iff (!axi_aresetn)
                o_rvalid |-> !o_arready
        ) else report_problem("Read accepted while a read response was pending");

        a_b_hold : assert property (
                @(posedge axi_aclk) disable iff (!axi_aresetn)
                (o_bvalid && !i_bready) |=> (o_bvalid && $stable(o_bresp))
        ) else report_problem("Write response dropped or changed while BREADY was low");

        a_r_hold : assert property (
                @(posedge axi_aclk) disable iff (!axi_aresetn)
                (o_rvalid && !i_rready) |=>
                        (o_rvalid && $stable(o_rdata) && $stable(o_rresp))
        ) else report_problem("Read response dropped or changed while RREADY was low");

        // Push into an empty FIFO shows on the stream in the next cycle
        a_tx_visible : assert property (
                @(posedge axi_aclk) disable iff (!axi_aresetn)
                (i_awvalid && o_awready && i_awaddr == REG_TXDATA && !o_tx_valid) |=>
                        (o_tx_valid && o_tx_data == $past(i_wdata))
        ) else report_problem("Pushed word not visible on the transmit stream");

        initial begin
                #(CLK_PERIOD * TEST_CYCLES * 4);
                report_problem("Watchdog expired before the tests finished");
        end

        // ------------------------------------------------------------------
        // Test sequence
        // ------------------------------------------------------------------
        initial begin
                data_t word;
                void'($urandom(32'hddef_9721));
                axi_aresetn = 1'b0;
                i_awaddr    = '0;
                i_awvalid   = 1'b0;
                i_wdata     = '0;
                i_wvalid    = 1'b0;
                i_bready    = 1'b1;
                i_araddr    = '0;
                i_arvalid   = 1'b0;
                i_rready    = 1'b1;
                i_rx_valid  = 1'b0;
                i_rx_data   = '0;
                rx_done     = 1'b0;
                repeat (16) @(posedge axi_aclk);
                #10;
                axi_aresetn = 1'b1;

                // Idle outputs after reset
                @(negedge axi_aclk);
                check_value("o_awready", 1'b0, o_awready);
                check_value("o_wready", 1'b0, o_wready);
                check_value("o_arready", 1'b0, o_arready);
                check_value("o_bvalid", 1'b0, o_bvalid);
                check_value("o_rvalid", 1'b0, o_rvalid);
                check_value("o_tx_valid", 1'b0, o_tx_valid);
                check_value("o_rx_ready", 1'b1, o_rx_ready);
                read_reg(REG_STATUS, status_word(0, 0), RESP_OKAY, 1'b1);

                // Transmit order under random throttling
                tx_mode = TX_RANDOM;
                repeat (10) begin
                        word = $urandom;
                        tx_model.push_back(word);
                        write_reg(REG_TXDATA, word, RESP_OKAY);
                end
                tx_mode = TX_OPEN;
                wait_tx_drained();

                // Transmit full, ninth word refused
                tx_mode = TX_HOLD;
                repeat (TX_DEPTH) begin
                        word = $urandom;
                        tx_model.push_back(word);
                        write_reg(REG_TXDATA, word, RESP_OKAY);
                end
                read_reg(REG_STATUS, status_word(TX_DEPTH, 0), RESP_OKAY, 1'b1);
                write_reg(REG_TXDATA, $urandom, RESP_SLVERR);
                tx_mode = TX_OPEN;
                wait_tx_drained();

                // Receive path, fifth word stalls until a pop
                fork
                        offer_rx_words(RX_DEPTH + 1);
                join_none
                @(negedge axi_aclk);
                while (o_rx_ready) @(negedge axi_aclk);
                check_value("words taken before o_rx_ready fell", RX_DEPTH, rx_model.size());
                read_reg(REG_STATUS, status_word(0, RX_DEPTH), RESP_OKAY, 1'b1);
                repeat (RX_DEPTH) begin
                        read_reg(REG_RXDATA, rx_model.pop_front(), RESP_OKAY, 1'b1);
                end
                while (!rx_done) @(negedge axi_aclk);
                read_reg(REG_RXDATA, rx_model.pop_front(), RESP_OKAY, 1'b1);

                // Empty pop and access errors
                read_reg(REG_RXDATA, '0, RESP_SLVERR, 1'b1);
                read_reg(REG_STATUS, status_word(0, 0), RESP_OKAY, 1'b1);
                write_reg(REG_STATUS, $urandom, RESP_SLVERR);
                write_reg(REG_RXDATA, $urandom, RESP_SLVERR);
                read_reg(REG_TXDATA, '0, RESP_SLVERR, 1'b0);
                write_reg(4'hC, $urandom, RESP_DECERR);
                read_reg(4'hC, '0, RESP_DECERR, 1'b0);

                // Response back-pressure on both channels
                hold_responses(6);
                wait_tx_drained();

                $display("Test passed");
                $finish;
        end

endmodule : tb_mbox_top

`default_nettype wire

/* build.f */
logic/mbox_pkg.sv
logic/fifo_flags.sv
logic/gaxi_fifo_sync.sv
logic/axil_mbox_regs.sv
logic/mbox_top.sv
tb/tb_mbox_top.sv
